// File: activation_lut.sv
`timescale 1ns/100ps
`default_nettype none

module activation_lut #(
	parameter int NUM_NEURONS = 8,
	localparam int NW = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
	input wire clk,
	input wire rst,
	input wire we_i,
	input wire [rnn_pkg::LUT_ADDR_W-1:0] addr_i,
	input wire rnn_pkg::lut_word_t data_i,
	input wire sel_load_i,
	input wire rnn_pkg::act_sel_e act_sel_i,
	input wire in_valid_i,
	input wire [NW-1:0] in_idx_i,
	input wire rnn_pkg::q16_t in_data_i,
	output logic out_valid_o,
	output logic [NW-1:0] out_idx_o,
	output rnn_pkg::q16_t out_data_o
);

	rnn_pkg::lut_word_t table_mem [rnn_pkg::LUT_DEPTH];
	rnn_pkg::act_sel_e sel_q;

	rnn_pkg::q16_t arg;
	rnn_pkg::q16_t mag;
	rnn_pkg::act_arg_u arg_u;
	logic [rnn_pkg::LUT_ADDR_W-1:0] rd_lo;
	logic [rnn_pkg::LUT_ADDR_W-1:0] rd_hi;

	logic s1_valid;
	logic [NW-1:0] s1_idx;
	rnn_pkg::lut_word_t s1_lo;
	rnn_pkg::lut_word_t s1_hi;
	logic [7:0] s1_frac;
	logic s1_sat;
	logic s1_neg;
	logic s1_sig;

	logic [8:0] w_lo;
	logic [39:0] interp;
	rnn_pkg::q16_t t_mag;
	rnn_pkg::q16_t t_sgn;
	rnn_pkg::q16_t result;

	// sigmoid(x) = tanh(x/2)/2 + 1/2
	assign arg = (sel_q == rnn_pkg::ACT_SIGMOID) ? (in_data_i >>> 1) : in_data_i;
	assign mag = arg[31] ? -arg : arg;

	always_comb begin
		arg_u.raw = mag;
		rd_lo = {1'b0, arg_u.f.lut_idx};
		rd_hi = rd_lo + 1'b1;
	end

	// select is loaded when a run is accepted
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= rnn_pkg::ACT_TANH;
			s1_valid <= 1'b0;
			out_valid_o <= 1'b0;
		end else begin
			if (sel_load_i)
				sel_q <= act_sel_i;
			s1_valid <= in_valid_i;
			out_valid_o <= s1_valid;
		end
	end

	// table write port and stage 1 reads
	always_ff @(posedge clk) begin
		if (we_i)
			table_mem[addr_i] <= data_i;
		s1_lo <= table_mem[rd_lo];
		s1_hi <= table_mem[rd_hi];
		s1_frac <= arg_u.f.frac;
		s1_sat <= |arg_u.f.sat_bits;
		s1_neg <= arg[31];
		s1_sig <= (sel_q == rnn_pkg::ACT_SIGMOID);
		s1_idx <= in_idx_i;
	end

	// linear interpolation between neighbouring entries
	always_comb begin
		w_lo = 9'd256 - {1'b0, s1_frac};
		interp = s1_lo * w_lo + s1_hi * s1_frac;
		t_mag = s1_sat ? rnn_pkg::ONE_Q : rnn_pkg::q16_t'(interp[39:8]);
		t_sgn = s1_neg ? -t_mag : t_mag;
		if (s1_sig)
			result = (t_sgn >>> 1) + rnn_pkg::HALF_Q;
		else
			result = t_sgn;
	end

	always_ff @(posedge clk) begin
		out_data_o <= result;
		out_idx_o <= s1_idx;
	end

endmodule

`default_nettype wire

// File: coef_mem.sv
`timescale 1ns/100ps
`default_nettype none

module coef_mem #(
	parameter int NUM_INPUTS = 16,
	parameter int NUM_NEURONS = 8,
	localparam int DEPTH = NUM_INPUTS * NUM_NEURONS + NUM_NEURONS,
	localparam int CAW = $clog2(DEPTH),
	localparam int IW = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1,
	localparam int NW = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
	input wire clk,
	input wire we_i,
	input wire [CAW-1:0] addr_i,
	input wire rnn_pkg::coef_t data_i,
	input wire [IW-1:0] input_idx_i,
	input wire [NW-1:0] neuron_idx_i,
	output rnn_pkg::coef_t weight_o,
	output rnn_pkg::coef_t bias_o
);

	rnn_pkg::coef_t mem [DEPTH];
	logic [CAW-1:0] w_addr;
	logic [CAW-1:0] b_addr;

	// weight for input i, neuron n at i*NUM_NEURONS+n, biases after the weights
	assign w_addr = CAW'(input_idx_i) * CAW'(NUM_NEURONS) + CAW'(neuron_idx_i);
	assign b_addr = CAW'(NUM_INPUTS * NUM_NEURONS) + CAW'(neuron_idx_i);

	always_ff @(posedge clk) begin
		if (we_i)
			mem[addr_i] <= data_i;
	end

	assign weight_o = mem[w_addr];
	assign bias_o = mem[b_addr];

endmodule

`default_nettype wire

// File: dense_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module dense_fsm (
	input wire clk,
	input wire rst,
	input wire start_i,
	input wire last_input_i,
	input wire last_neuron_i,
	output logic cnt_clear_o,
	output logic cnt_step_o,
	output logic load_bias_o,
	output logic accum_o,
	output logic busy_o,
	output logic done_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BIAS,
		ST_PRODUCT,
		ST_DRAIN
	} state_e;

	state_e state;
	state_e state_nx;
	logic [1:0] drain_cnt;
	logic start_ok;

	// start only counts while idle
	assign start_ok = (state == ST_IDLE) && start_i;

	always_comb begin
		state_nx = state;
		case (state)
			ST_IDLE: begin
				if (start_ok)
					state_nx = ST_PRODUCT;
			end
			ST_BIAS: begin
				state_nx = ST_PRODUCT;
			end
			ST_PRODUCT: begin
				if (last_input_i)
					state_nx = last_neuron_i ? ST_DRAIN : ST_BIAS;
			end
			ST_DRAIN: begin
				// acc_valid, then two activation stages
				if (drain_cnt == 2'd2)
					state_nx = ST_IDLE;
			end
			default: begin
				state_nx = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			drain_cnt <= 2'd0;
		end else begin
			state <= state_nx;
			if (state == ST_DRAIN)
				drain_cnt <= drain_cnt + 2'd1;
			else
				drain_cnt <= 2'd0;
		end
	end

	// first bias loads in the start cycle, the counter idles at zero
	assign cnt_clear_o = start_ok;
	assign load_bias_o = start_ok || (state == ST_BIAS);
	assign accum_o = (state == ST_PRODUCT);
	assign cnt_step_o = (state == ST_PRODUCT);
	assign busy_o = (state != ST_IDLE);
	assign done_o = (state == ST_DRAIN) && (drain_cnt == 2'd2);

endmodule

`default_nettype wire

// File: dense_layer_chk.sv
`timescale 1ns/100ps
`default_nettype none

module dense_layer_chk #(
	parameter int NW = 3
) (
	input wire clk,
	input wire rst,
	input wire busy_o,
	input wire done_o,
	input wire out_valid_o,
	input wire [NW-1:0] out_idx_o
);

	logic [NW-1:0] prev_idx;
	logic have_prev;

	// last output index seen in the current run
	always_ff @(posedge clk) begin
		if (rst || done_o) begin
			have_prev <= 1'b0;
		end else if (out_valid_o) begin
			have_prev <= 1'b1;
			prev_idx <= out_idx_o;
		end
	end

	a_valid_busy: assert property (@(posedge clk) disable iff (rst)
		out_valid_o |-> busy_o)
		else $error("out_valid_o seen while busy_o is low");

	a_done_valid: assert property (@(posedge clk) disable iff (rst)
		done_o |-> out_valid_o)
		else $error("done_o seen without out_valid_o");

	a_idx_step: assert property (@(posedge clk) disable iff (rst)
		(out_valid_o && have_prev) |-> (out_idx_o == prev_idx + NW'(1)))
		else $error("out_idx_o did not rise by one");

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !out_valid_o)
		else $error("out_valid_o high in the cycle after reset");

endmodule

`default_nettype wire

// File: dense_layer_top.sv
`timescale 1ns/100ps
`default_nettype none

module dense_layer_top #(
	parameter int NUM_INPUTS = 16,
	parameter int NUM_NEURONS = 8,
	localparam int CAW = $clog2(NUM_INPUTS * NUM_NEURONS + NUM_NEURONS),
	localparam int IW = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1,
	localparam int NW = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
	input wire clk,
	input wire rst,
	input wire coef_we_i,
	input wire [CAW-1:0] coef_addr_i,
	input wire rnn_pkg::coef_t coef_data_i,
	input wire lut_we_i,
	input wire [rnn_pkg::LUT_ADDR_W-1:0] lut_addr_i,
	input wire rnn_pkg::lut_word_t lut_data_i,
	input wire feat_we_i,
	input wire [IW-1:0] feat_addr_i,
	input wire rnn_pkg::q16_t feat_data_i,
	input wire start_i,
	input wire rnn_pkg::act_sel_e act_sel_i,
	output logic busy_o,
	output logic done_o,
	output logic out_valid_o,
	output logic [NW-1:0] out_idx_o,
	output rnn_pkg::q16_t out_data_o
);

	logic cnt_clear;
	logic cnt_step;
	logic load_bias;
	logic accum;
	logic last_input;
	logic last_neuron;
	logic [IW-1:0] input_idx;
	logic [NW-1:0] neuron_idx;
	rnn_pkg::coef_t weight;
	rnn_pkg::coef_t bias;
	rnn_pkg::q16_t feature;
	logic acc_valid;
	logic [NW-1:0] acc_idx;
	rnn_pkg::q16_t acc;

	dense_fsm u_fsm (
		.clk(clk),
		.rst(rst),
		.start_i(start_i),
		.last_input_i(last_input),
		.last_neuron_i(last_neuron),
		.cnt_clear_o(cnt_clear),
		.cnt_step_o(cnt_step),
		.load_bias_o(load_bias),
		.accum_o(accum),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	neuron_counter #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_counter (
		.clk(clk),
		.rst(rst),
		.clear_i(cnt_clear),
		.step_i(cnt_step),
		.input_idx_o(input_idx),
		.neuron_idx_o(neuron_idx),
		.last_input_o(last_input),
		.last_neuron_o(last_neuron)
	);

	coef_mem #(
		.NUM_INPUTS(NUM_INPUTS),
		.NUM_NEURONS(NUM_NEURONS)
	) u_coef (
		.clk(clk),
		.we_i(coef_we_i),
		.addr_i(coef_addr_i),
		.data_i(coef_data_i),
		.input_idx_i(input_idx),
		.neuron_idx_i(neuron_idx),
		.weight_o(weight),
		.bias_o(bias)
	);

	feature_mem #(
		.NUM_INPUTS(NUM_INPUTS)
	) u_feat (
		.clk(clk),
		.we_i(feat_we_i),
		.addr_i(feat_addr_i),
		.data_i(feat_data_i),
		.idx_i(input_idx),
		.feature_o(feature)
	);

	mac_accum #(
		.NUM_NEURONS(NUM_NEURONS)
	) u_mac (
		.clk(clk),
		.rst(rst),
		.load_bias_i(load_bias),
		.accum_i(accum),
		.bias_i(bias),
		.weight_i(weight),
		.feature_i(feature),
		.neuron_idx_i(neuron_idx),
		.acc_valid_o(acc_valid),
		.acc_idx_o(acc_idx),
		.acc_o(acc)
	);

	// the accepted start also loads the activation select
	activation_lut #(
		.NUM_NEURONS(NUM_NEURONS)
	) u_act (
		.clk(clk),
		.rst(rst),
		.we_i(lut_we_i),
		.addr_i(lut_addr_i),
		.data_i(lut_data_i),
		.sel_load_i(cnt_clear),
		.act_sel_i(act_sel_i),
		.in_valid_i(acc_valid),
		.in_idx_i(acc_idx),
		.in_data_i(acc),
		.out_valid_o(out_valid_o),
		.out_idx_o(out_idx_o),
		.out_data_o(out_data_o)
	);

endmodule

`default_nettype wire

// File: feature_mem.sv
`timescale 1ns/100ps
`default_nettype none

module feature_mem #(
	parameter int NUM_INPUTS = 16,
	localparam int IW = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1
) (
	input wire clk,
	input wire we_i,
	input wire [IW-1:0] addr_i,
	input wire rnn_pkg::q16_t data_i,
	input wire [IW-1:0] idx_i,
	output rnn_pkg::q16_t feature_o
);

	// one Q16.16 word per input
	rnn_pkg::q16_t mem [NUM_INPUTS];

	always_ff @(posedge clk) begin
		if (we_i)
			mem[addr_i] <= data_i;
	end

	assign feature_o = mem[idx_i];

endmodule

`default_nettype wire

// File: mac_accum.sv
`timescale 1ns/100ps
`default_nettype none

module mac_accum #(
	parameter int NUM_NEURONS = 8,
	localparam int NW = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
	input wire clk,
	input wire rst,
	input wire load_bias_i,
	input wire accum_i,
	input wire rnn_pkg::coef_t bias_i,
	input wire rnn_pkg::coef_t weight_i,
	input wire rnn_pkg::q16_t feature_i,
	input wire [NW-1:0] neuron_idx_i,
	output logic acc_valid_o,
	output logic [NW-1:0] acc_idx_o,
	output rnn_pkg::q16_t acc_o
);

	rnn_pkg::q16_t acc;
	logic signed [39:0] prod;
	logic pending;

	// low 32 bits of weight*feature, same as the Q16.16 product of weight<<16
	assign prod = weight_i * feature_i;

	always_ff @(posedge clk) begin
		if (load_bias_i)
			acc <= rnn_pkg::q16_t'(bias_i) <<< rnn_pkg::FRAC_BITS;
		else if (accum_i)
			acc <= acc + prod[31:0];
		if (accum_i)
			acc_idx_o <= neuron_idx_i;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pending <= 1'b0;
		else
			pending <= accum_i;
	end

	// sum is complete in the first cycle without a product
	assign acc_valid_o = pending && !accum_i;
	assign acc_o = acc >>> rnn_pkg::WEIGHT_SHIFT;

endmodule

`default_nettype wire

// File: neuron_counter.sv
`timescale 1ns/100ps
`default_nettype none

module neuron_counter #(
	parameter int NUM_INPUTS = 16,
	parameter int NUM_NEURONS = 8,
	localparam int IW = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1,
	localparam int NW = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1
) (
	input wire clk,
	input wire rst,
	input wire clear_i,
	input wire step_i,
	output logic [IW-1:0] input_idx_o,
	output logic [NW-1:0] neuron_idx_o,
	output logic last_input_o,
	output logic last_neuron_o
);

	assign last_input_o = (input_idx_o == IW'(NUM_INPUTS - 1));
	assign last_neuron_o = (neuron_idx_o == NW'(NUM_NEURONS - 1));

	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			input_idx_o <= '0;
			neuron_idx_o <= '0;
		end else if (step_i) begin
			if (last_input_o) begin
				input_idx_o <= '0;
				// both wrap after the last product of the run
				if (last_neuron_o)
					neuron_idx_o <= '0;
				else
					neuron_idx_o <= neuron_idx_o + NW'(1);
			end else begin
				input_idx_o <= input_idx_o + IW'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: rnn_pkg.sv
`default_nettype none

package rnn_pkg;

	// fixed-point formats
	localparam int FRAC_BITS = 16;
	localparam int WEIGHT_SHIFT = 8;

	// tanh table, entry k holds tanh(k/256)
	localparam int LUT_DEPTH = 1025;
	localparam int LUT_ADDR_W = 11;

	typedef logic signed [31:0] q16_t;
	typedef logic signed [7:0] coef_t;
	typedef logic [31:0] lut_word_t;

	typedef enum logic {
		ACT_TANH = 1'b0,
		ACT_SIGMOID = 1'b1
	} act_sel_e;

	localparam q16_t ONE_Q = q16_t'(1 << FRAC_BITS);
	localparam q16_t HALF_Q = q16_t'(1 << (FRAC_BITS - 1));

	// activation magnitude, seen whole or split for the table lookup
	typedef union packed {
		q16_t raw;
		struct packed {
			// nonzero means magnitude of 4.0 or more
			logic [13:0] sat_bits;
			logic [9:0] lut_idx;
			logic [7:0] frac;
		} f;
	} act_arg_u;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -sv -f vlog.f \
	--top-module tb_dense_layer -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
grep -q "All tests passed" sim.log

// File: tb_dense_layer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dense_layer;

	localparam int NI = 16;
	localparam int NN = 8;
	localparam int IW = 4;
	localparam int NW = 3;
	localparam int CDEPTH = NI * NN + NN;
	localparam int CAW = 8;
	localparam int RUNS = 8;
	localparam int LOAD_CYCLES = rnn_pkg::LUT_DEPTH + RUNS * (CDEPTH + NI + 4) + 40;
	localparam int WD_CYCLES = 2 * (RUNS * (NN * (NI + 1) + 10) + LOAD_CYCLES);

	logic clk = 1'b0;
	logic rst;
	logic coef_we_i;
	logic [CAW-1:0] coef_addr_i;
	rnn_pkg::coef_t coef_data_i;
	logic lut_we_i;
	logic [rnn_pkg::LUT_ADDR_W-1:0] lut_addr_i;
	rnn_pkg::lut_word_t lut_data_i;
	logic feat_we_i;
	logic [IW-1:0] feat_addr_i;
	rnn_pkg::q16_t feat_data_i;
	logic start_i;
	rnn_pkg::act_sel_e act_sel_i;
	logic busy_o;
	logic done_o;
	logic out_valid_o;
	logic [NW-1:0] out_idx_o;
	rnn_pkg::q16_t out_data_o;

	// copies of what the DUT holds, for the model
	rnn_pkg::coef_t coefs [CDEPTH];
	rnn_pkg::q16_t feats [NI];
	rnn_pkg::lut_word_t table_m [rnn_pkg::LUT_DEPTH];
	int sat_sign [NN];

	dense_layer_top #(.NUM_INPUTS(NI), .NUM_NEURONS(NN)) DUT (.*);

	bind dense_layer_top dense_layer_chk #(.NW(NW)) u_chk (
		.clk(clk), .rst(rst), .busy_o(busy_o), .done_o(done_o),
		.out_valid_o(out_valid_o), .out_idx_o(out_idx_o)
	);

	always #2 clk = ~clk;

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_q16(input string name, input rnn_pkg::q16_t got,
		input rnn_pkg::q16_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_idx(input string name, input logic [NW-1:0] got,
		input logic [NW-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// tanh/sigmoid by table, interpolated, saturated past 4.0
	function automatic rnn_pkg::q16_t act_model(input rnn_pkg::q16_t x,
		input rnn_pkg::act_sel_e sel);
		rnn_pkg::q16_t a;
		rnn_pkg::act_arg_u u;
		longint unsigned lo;
		longint unsigned hi;
		longint unsigned t;
		rnn_pkg::q16_t tm;
		a = (sel == rnn_pkg::ACT_SIGMOID) ? (x >>> 1) : x;
		u.raw = a[31] ? -a : a;
		lo = table_m[u.f.lut_idx];
		hi = table_m[int'(u.f.lut_idx) + 1];
		t = (lo * (256 - u.f.frac) + hi * u.f.frac) >> 8;
		tm = (u.f.sat_bits != 0) ? rnn_pkg::ONE_Q : rnn_pkg::q16_t'(t[31:0]);
		if (a[31])
			tm = -tm;
		if (sel == rnn_pkg::ACT_SIGMOID)
			return (tm >>> 1) + rnn_pkg::HALF_Q;
		return tm;
	endfunction

	function automatic rnn_pkg::q16_t neuron_model(input int n, input rnn_pkg::act_sel_e sel);
		rnn_pkg::q16_t acc;
		longint p;
		acc = rnn_pkg::q16_t'(coefs[NI * NN + n]) <<< 16;
		for (int i = 0; i < NI; i++) begin
			p = longint'(coefs[i * NN + n]) * longint'(feats[i]);
			acc = acc + rnn_pkg::q16_t'(p[31:0]);
		end
		return act_model(acc >>> 8, sel);
	endfunction

	task automatic write_table();
		for (int k = 0; k < rnn_pkg::LUT_DEPTH; k++) begin
			table_m[k] = rnn_pkg::lut_word_t'($rtoi($tanh(k / 256.0) * 65536.0 + 0.5));
			@(negedge clk);
			lut_we_i = 1'b1;
			lut_addr_i = k[rnn_pkg::LUT_ADDR_W-1:0];
			lut_data_i = table_m[k];
		end
		@(negedge clk);
		lut_we_i = 1'b0;
	endtask

	// big=1 gives same-signed weights per neuron for saturation
	task automatic write_coefs(input bit big);
		for (int n = 0; n < NN; n++)
			sat_sign[n] = $urandom_range(1);
		for (int a = 0; a < CDEPTH; a++) begin
			if (big && a < NI * NN)
				coefs[a] = rnn_pkg::coef_t'(sat_sign[a % NN] ? -$urandom_range(127, 32)
					: $urandom_range(127, 32));
			else
				coefs[a] = rnn_pkg::coef_t'($urandom);
			@(negedge clk);
			coef_we_i = 1'b1;
			coef_addr_i = a[CAW-1:0];
			coef_data_i = coefs[a];
		end
		@(negedge clk);
		coef_we_i = 1'b0;
	endtask

	task automatic write_features(input bit big);
		for (int i = 0; i < NI; i++) begin
			if (big)
				feats[i] = rnn_pkg::q16_t'(32'h80000 + $urandom_range(32'h40000));
			else
				feats[i] = rnn_pkg::q16_t'($urandom_range(32768)) - 16384;
			@(negedge clk);
			feat_we_i = 1'b1;
			feat_addr_i = i[IW-1:0];
			feat_data_i = feats[i];
		end
		@(negedge clk);
		feat_we_i = 1'b0;
	endtask

	// sat=1 also checks the saturated values, poke=1 tries a start mid-run
	task automatic run_layer(input rnn_pkg::act_sel_e sel, input bit sat, input bit poke);
		rnn_pkg::q16_t exp [NN];
		int outs;
		int dones;
		int cyc;
		logic done_last;
		outs = 0;
		dones = 0;
		cyc = 0;
		done_last = 1'b0;
		for (int n = 0; n < NN; n++)
			exp[n] = neuron_model(n, sel);
		@(negedge clk);
		start_i = 1'b1;
		act_sel_i = sel;
		@(negedge clk);
		start_i = 1'b0;
		check_flag("busy_o", busy_o, 1'b1);
		while (busy_o) begin
			if (out_valid_o) begin
				if (outs >= NN)
					fail_now("more outputs than neurons in one run");
				check_idx("out_idx_o", out_idx_o, outs[NW-1:0]);
				check_q16("out_data_o", out_data_o, exp[outs]);
				if (sel == rnn_pkg::ACT_SIGMOID &&
					(out_data_o < 0 || out_data_o > rnn_pkg::ONE_Q))
					fail_now("sigmoid output outside 0 to 1.0");
				if (sat && sel == rnn_pkg::ACT_TANH)
					check_q16("out_data_o", out_data_o,
						sat_sign[outs] ? -rnn_pkg::ONE_Q : rnn_pkg::ONE_Q);
				if (sat && sel == rnn_pkg::ACT_SIGMOID)
					check_q16("out_data_o", out_data_o, sat_sign[outs] ? 0 : rnn_pkg::ONE_Q);
				outs++;
			end
			if (done_o)
				dones++;
			done_last = done_o;
			start_i = (poke && cyc == 20);
			act_sel_i = (poke && cyc == 20) ? rnn_pkg::act_sel_e'(~sel) : sel;
			@(negedge clk);
			cyc++;
		end
		start_i = 1'b0;
		check_count("output count", outs, NN);
		check_count("done_o count", dones, 1);
		// busy_o drops right after the done_o cycle
		check_flag("done_o before busy_o fell", done_last, 1'b1);
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1);
	end

	initial begin
		void'($urandom(32'hfc1a829c));
		rst = 1'b1;
		coef_we_i = 1'b0;
		coef_addr_i = '0;
		coef_data_i = '0;
		lut_we_i = 1'b0;
		lut_addr_i = '0;
		lut_data_i = '0;
		feat_we_i = 1'b0;
		feat_addr_i = '0;
		feat_data_i = '0;
		start_i = 1'b0;
		act_sel_i = rnn_pkg::ACT_TANH;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		write_table();

		write_coefs(1'b0);
		write_features(1'b0);
		run_layer(rnn_pkg::ACT_TANH, 1'b0, 1'b0);

		write_coefs(1'b0);
		write_features(1'b0);
		run_layer(rnn_pkg::ACT_SIGMOID, 1'b0, 1'b0);

		// arguments well past 4.0
		write_coefs(1'b1);
		write_features(1'b1);
		run_layer(rnn_pkg::ACT_TANH, 1'b1, 1'b0);
		run_layer(rnn_pkg::ACT_SIGMOID, 1'b1, 1'b0);

		// back to back, stray start during the second
		write_coefs(1'b0);
		write_features(1'b0);
		run_layer(rnn_pkg::ACT_TANH, 1'b0, 1'b0);
		write_features(1'b0);
		run_layer(rnn_pkg::ACT_SIGMOID, 1'b0, 1'b1);

		// reset lands in the cycle where the last output and done_o are due
		@(negedge clk);
		start_i = 1'b1;
		act_sel_i = rnn_pkg::ACT_TANH;
		@(negedge clk);
		start_i = 1'b0;
		repeat (NN * (NI + 1)) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_flag("busy_o", busy_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		check_flag("out_valid_o", out_valid_o, 1'b0);
		repeat (9) @(negedge clk);
		rst = 1'b0;
		write_features(1'b0);
		run_layer(rnn_pkg::ACT_TANH, 1'b0, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rnn_pkg.sv
dense_fsm.sv
neuron_counter.sv
coef_mem.sv
feature_mem.sv
mac_accum.sv
activation_lut.sv
dense_layer_top.sv
dense_layer_chk.sv
tb_dense_layer.sv
